//--- balance_types_pkg.sv
// balance controller data types
package balance_types_pkg;

  ///////////////////////////////
  // pitch path
  ///////////////////////////////
  typedef logic signed [15:0] ptch_t;      // raw pitch from inertial sensor
  typedef logic signed [9:0]  ptch_err_t;  // pitch error after saturation
  typedef logic signed [17:0] integ_t;     // integrator, top 12 bits form I term
  typedef logic signed [6:0]  d_diff_t;    // saturated derivative difference

  ///////////////////////////////
  // steering and drive path
  ///////////////////////////////
  // lft_ld - rght_ld from the load cells
  typedef logic signed [11:0] ld_diff_t;

  // PID sum, also the per-wheel torque
  typedef logic signed [15:0] torque_t;

  // unsigned motor speed, 2047 is full scale
  typedef logic [10:0] spd_t;

endpackage : balance_types_pkg

//--- balance_cfg_pkg.sv
// balance controller constants
package balance_cfg_pkg;

  ///////////////////////////////
  // coefficient defaults
  ///////////////////////////////
  localparam int P_COEFF         = 14;    // proportional gain
  localparam int D_COEFF         = 20;    // derivative gain
  localparam int LOW_TORQUE_BAND = 70;    // roughly 5 * P_COEFF
  localparam int GAIN_MULTIPLIER = 15;    // 1 + MIN_DUTY / LOW_TORQUE_BAND
  localparam int MIN_DUTY        = 980;   // duty that stiffens the motor
  localparam int SPD_WARN        = 1536;  // over-speed warning level

  ///////////////////////////////
  // saturation limits
  ///////////////////////////////
  localparam balance_types_pkg::ptch_err_t ERR_MAX   = 10'sh1FF;  // +511
  localparam balance_types_pkg::ptch_err_t ERR_MIN   = 10'sh200;  // -512
  localparam balance_types_pkg::d_diff_t   DDIFF_MAX = 7'sh3F;    // +63
  localparam balance_types_pkg::d_diff_t   DDIFF_MIN = 7'sh40;    // -64
  localparam balance_types_pkg::spd_t      SPD_MAX   = 11'h7FF;   // 2047 unsigned

endpackage : balance_cfg_pkg

//--- pitch_pid.sv
// pitch PID controller
module pitch_pid #(
  parameter int P_COEFF = balance_cfg_pkg::P_COEFF,
  parameter int D_COEFF = balance_cfg_pkg::D_COEFF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        vld,        // new inertial reading this cycle
  input  balance_types_pkg::ptch_t    ptch,       // measured pitch
  input  logic                        rider_off,  // no weight on the load cells
  input  logic                        pwr_up,     // platform enabled
  output balance_types_pkg::torque_t  pid_cntrl   // P + I + D
);

  import balance_types_pkg::*;
  import balance_cfg_pkg::*;

  ptch_err_t ptch_err;      // saturated pitch error
  torque_t   p_term;

  integ_t    integ;         // running sum of errors
  integ_t    err_ext;       // error sign extended to integrator width
  integ_t    nxt_integ;
  logic      ovfl;          // signed overflow on this add
  torque_t   i_term;

  ptch_err_t err_q1;        // error one reading back
  ptch_err_t err_q2;        // error two readings back
  logic signed [10:0] d_raw;  // one extra bit so full-scale swings saturate cleanly
  d_diff_t   d_sat;
  torque_t   d_term;

  ///////////////////////////////
  // error and P term
  ///////////////////////////////
  always_comb begin
    if (ptch > ERR_MAX)
      ptch_err = ERR_MAX;    // clamp positive
    else if (ptch < ERR_MIN)
      ptch_err = ERR_MIN;    // clamp negative
    else
      ptch_err = ptch[9:0];
  end

  assign p_term = torque_t'(ptch_err) * torque_t'(P_COEFF);  // at most 14 * 512, no wrap

  ///////////////////////////////
  // I term
  ///////////////////////////////
  assign err_ext   = integ_t'(ptch_err);
  assign nxt_integ = integ + err_ext;

  // operands agree in sign but the sum does not
  assign ovfl = (integ[17] == err_ext[17]) && (nxt_integ[17] != integ[17]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integ <= '0;
    end else if (rider_off) begin
      integ <= '0;                // rider stepped off, drop windup
    end else if (vld && !ovfl) begin
      integ <= nxt_integ;         // freeze instead of wrapping
    end
  end

  // only the top 12 bits count, and nothing while powered down
  assign i_term = pwr_up ? torque_t'($signed(integ[17:6])) : '0;

  ///////////////////////////////
  // D term
  ///////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q1 <= '0;
      err_q2 <= '0;
    end else if (vld) begin
      err_q1 <= ptch_err;         // shift the error history
      err_q2 <= err_q1;
    end
  end

  assign d_raw = 11'(ptch_err) - 11'(err_q2);  // current minus two readings back

  always_comb begin
    if (d_raw > DDIFF_MAX)
      d_sat = DDIFF_MAX;
    else if (d_raw < DDIFF_MIN)
      d_sat = DDIFF_MIN;
    else
      d_sat = d_raw[6:0];
  end

  assign d_term = torque_t'(d_sat) * torque_t'(D_COEFF);

  // wraps at 16 bits like the drive hardware expects
  assign pid_cntrl = p_term + i_term + d_term;

endmodule : pitch_pid

//--- wheel_shaper.sv
// single wheel torque shaper
module wheel_shaper #(
  parameter int LOW_TORQUE_BAND = balance_cfg_pkg::LOW_TORQUE_BAND,
  parameter int GAIN_MULTIPLIER = balance_cfg_pkg::GAIN_MULTIPLIER,
  parameter int MIN_DUTY        = balance_cfg_pkg::MIN_DUTY
) (
  input  balance_types_pkg::torque_t  torque,  // desired wheel torque
  output logic                        rev,     // 1 runs the motor in reverse
  output balance_types_pkg::spd_t     spd      // ungated speed
);

  import balance_types_pkg::*;
  import balance_cfg_pkg::*;

  localparam logic [15:0] BAND = 16'(LOW_TORQUE_BAND);  // unsigned band edge

  logic [15:0] trq_mag;      // |torque|, unsigned so -32768 stays large
  torque_t     duty_push;    // torque pushed away from zero by MIN_DUTY
  torque_t     gain_trq;     // torque scaled inside the low band
  torque_t     shaped;
  logic [15:0] shp_mag;      // |shaped|

  ///////////////////////////////
  // shaping
  ///////////////////////////////
  assign trq_mag = torque[15] ? 16'(-torque) : 16'(torque);

  // add or subtract the minimum duty depending on direction
  assign duty_push = torque[15] ? torque - torque_t'(MIN_DUTY)
                                : torque + torque_t'(MIN_DUTY);

  assign gain_trq = torque * torque_t'(GAIN_MULTIPLIER);  // truncated to 16 bits

  // outside the band use min duty, inside use the steeper gain
  assign shaped = (trq_mag >= BAND) ? duty_push : gain_trq;

  ///////////////////////////////
  // direction and speed
  ///////////////////////////////
  assign rev = shaped[15];   // sign of shaped torque

  assign shp_mag = shaped[15] ? 16'(-shaped) : 16'(shaped);

  // anything above 11 bits clamps to full scale
  assign spd = (|shp_mag[15:11]) ? SPD_MAX : shp_mag[10:0];

endmodule : wheel_shaper

//--- motor_drive.sv
// steering mix and motor drive
module motor_drive #(
  parameter int LOW_TORQUE_BAND = balance_cfg_pkg::LOW_TORQUE_BAND,
  parameter int GAIN_MULTIPLIER = balance_cfg_pkg::GAIN_MULTIPLIER,
  parameter int MIN_DUTY        = balance_cfg_pkg::MIN_DUTY,
  parameter int SPD_WARN        = balance_cfg_pkg::SPD_WARN
) (
  input  balance_types_pkg::torque_t  pid_cntrl,     // from pitch controller
  input  balance_types_pkg::ld_diff_t ld_cell_diff,  // lft_ld - rght_ld
  input  logic                        en_steer,
  input  logic                        pwr_up,
  output balance_types_pkg::spd_t     lft_spd,
  output balance_types_pkg::spd_t     rght_spd,
  output logic                        lft_rev,
  output logic                        rght_rev,
  output logic                        too_fast       // to piezo warning
);

  import balance_types_pkg::*;

  localparam spd_t WARN_LVL = spd_t'(SPD_WARN);

  torque_t steer;                    // load difference / 8
  torque_t lft_trq, rght_trq;
  spd_t    lft_raw, rght_raw;        // speeds before power gating

  ///////////////////////////////
  // steering mix
  ///////////////////////////////
  assign steer    = torque_t'(ld_cell_diff >>> 3);  // arithmetic, keeps sign
  assign lft_trq  = en_steer ? pid_cntrl - steer : pid_cntrl;
  assign rght_trq = en_steer ? pid_cntrl + steer : pid_cntrl;

  wheel_shaper #(
    .LOW_TORQUE_BAND (LOW_TORQUE_BAND),
    .GAIN_MULTIPLIER (GAIN_MULTIPLIER),
    .MIN_DUTY        (MIN_DUTY)
  ) lft_shaper_i (.torque(lft_trq), .rev(lft_rev), .spd(lft_raw));

  wheel_shaper #(
    .LOW_TORQUE_BAND (LOW_TORQUE_BAND),
    .GAIN_MULTIPLIER (GAIN_MULTIPLIER),
    .MIN_DUTY        (MIN_DUTY)
  ) rght_shaper_i (.torque(rght_trq), .rev(rght_rev), .spd(rght_raw));

  // motors stay still until the platform is enabled
  assign lft_spd  = pwr_up ? lft_raw : '0;
  assign rght_spd = pwr_up ? rght_raw : '0;

  assign too_fast = (lft_spd > WARN_LVL) || (rght_spd > WARN_LVL);  // either wheel

endmodule : motor_drive

//--- balance_cntrl.sv
// self-balancing platform controller
module balance_cntrl #(
  parameter int P_COEFF         = balance_cfg_pkg::P_COEFF,
  parameter int D_COEFF         = balance_cfg_pkg::D_COEFF,
  parameter int LOW_TORQUE_BAND = balance_cfg_pkg::LOW_TORQUE_BAND,
  parameter int GAIN_MULTIPLIER = balance_cfg_pkg::GAIN_MULTIPLIER,
  parameter int MIN_DUTY        = balance_cfg_pkg::MIN_DUTY,
  parameter int SPD_WARN        = balance_cfg_pkg::SPD_WARN
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        vld,           // new inertial reading strobe
  input  balance_types_pkg::ptch_t    ptch,
  input  balance_types_pkg::ld_diff_t ld_cell_diff,
  input  logic                        rider_off,
  input  logic                        en_steer,
  input  logic                        pwr_up,
  output balance_types_pkg::spd_t     lft_spd,
  output balance_types_pkg::spd_t     rght_spd,
  output logic                        lft_rev,
  output logic                        rght_rev,
  output logic                        too_fast
);

  import balance_types_pkg::*;

  torque_t pid_cntrl;   // PID output into the drive

  ///////////////////////////////
  // pitch loop
  ///////////////////////////////
  pitch_pid #(
    .P_COEFF (P_COEFF),
    .D_COEFF (D_COEFF)
  ) pitch_pid_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld       (vld),
    .ptch      (ptch),
    .rider_off (rider_off),
    .pwr_up    (pwr_up),
    .pid_cntrl (pid_cntrl)
  );

  ///////////////////////////////
  // wheel drive
  ///////////////////////////////
  motor_drive #(
    .LOW_TORQUE_BAND (LOW_TORQUE_BAND),
    .GAIN_MULTIPLIER (GAIN_MULTIPLIER),
    .MIN_DUTY        (MIN_DUTY),
    .SPD_WARN        (SPD_WARN)
  ) motor_drive_i (
    .pid_cntrl    (pid_cntrl),
    .ld_cell_diff (ld_cell_diff),
    .en_steer     (en_steer),
    .pwr_up       (pwr_up),
    .lft_spd      (lft_spd),
    .rght_spd     (rght_spd),
    .lft_rev      (lft_rev),
    .rght_rev     (rght_rev),
    .too_fast     (too_fast)
  );

endmodule : balance_cntrl

//--- balance_checker.sv
// balance controller output checker
module balance_checker #(
  parameter logic [3:0] DONE_ID = 4'd7
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        vld,
  input  balance_types_pkg::ptch_t    ptch,
  input  balance_types_pkg::ld_diff_t ld_cell_diff,
  input  logic                        rider_off,
  input  logic                        en_steer,
  input  logic                        pwr_up,
  input  balance_types_pkg::spd_t     lft_spd,
  input  balance_types_pkg::spd_t     rght_spd,
  input  logic                        lft_rev,
  input  logic                        rght_rev,
  input  logic                        too_fast,
  input  logic [3:0]                  test_id,
  output int                          errors,
  output int                          checks,
  output logic                        report_done
);
  timeunit 1ns;
  timeprecision 100ps;

  import balance_types_pkg::*;

  // model copy of the controller constants
  localparam int P_COEFF   = 14;
  localparam int D_COEFF   = 20;
  localparam int BAND      = 70;
  localparam int GAIN      = 15;
  localparam int MIN_DUTY  = 980;
  localparam int SPD_WARN  = 1536;
  localparam int INTEG_MAX = 131071;    // 18-bit signed range
  localparam int INTEG_MIN = -131072;

  int   integ_m, q1_m, q2_m;   // model state
  int   err_now;
  int   e_lspd, e_rspd;
  logic e_lrev, e_rrev, e_fast;
  logic [3:0] cur_id;
  int   test_errs, test_checks, tests_run, tests_ok;

  function automatic int clamp(input int v, input int lo, input int hi);
    return (v > hi) ? hi : (v < lo) ? lo : v;
  endfunction

  function automatic int wrap16(input int v);
    logic signed [15:0] t;
    t = v[15:0];
    return int'(t);
  endfunction

  // band check, min duty push or low-band gain, then |x| capped at 2047
  function automatic void shape_wheel(input int trq, output logic rev, output int spd);
    int mag;
    int shaped;
    mag = (trq < 0) ? -trq : trq;
    if (mag >= BAND)
      shaped = wrap16((trq < 0) ? trq - MIN_DUTY : trq + MIN_DUTY);
    else
      shaped = wrap16(trq * GAIN);
    rev = (shaped < 0);
    spd = clamp((shaped < 0) ? -shaped : shaped, 0, 2047);
  endfunction

  ///////////////////////////////
  // reference model
  ///////////////////////////////
  function automatic void expect_outputs(
    input int p, input int ld, input logic steer_on, input logic pwr,
    input int integ_v, input int err_old,
    output int lspd, output int rspd, output logic lrev, output logic rrev,
    output logic fast);
    int err;
    int pid;
    int steer;
    err = clamp(p, -512, 511);
    pid = err * P_COEFF + clamp(err - err_old, -64, 63) * D_COEFF;
    if (pwr)
      pid = pid + (integ_v >>> 6);   // top 12 of 18 bits
    pid = wrap16(pid);
    steer = steer_on ? (ld >>> 3) : 0;
    shape_wheel(wrap16(pid - steer), lrev, lspd);
    shape_wheel(wrap16(pid + steer), rrev, rspd);
    if (!pwr) begin
      lspd = 0;
      rspd = 0;
    end
    fast = (lspd > SPD_WARN) || (rspd > SPD_WARN);
  endfunction

  task automatic compare_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
      errors++;
      test_errs++;
    end
  endtask

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "power-down gating";
      4'd2:    return "P and D response";
      4'd3:    return "integral windup and freeze";
      4'd4:    return "rider-off clear";
      4'd5:    return "steering";
      default: return "torque shaping and over-speed";
    endcase
  endfunction

  initial begin
    errors = 0;
    checks = 0;
    report_done = 1'b0;
    cur_id = 4'd0;
    test_errs = 0;
    test_checks = 0;
    tests_run = 0;
    tests_ok = 0;
  end

  ///////////////////////////////
  // compare, then advance model
  ///////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integ_m = 0;
      q1_m = 0;
      q2_m = 0;
    end else begin
      if (test_id != cur_id) begin
        if (cur_id != 4'd0) begin   // close out the finished test
          $display("test %0d (%s): %s, %0d checks, %0d errors", cur_id, test_name(cur_id),
                   (test_errs == 0) ? "pass" : "fail", test_checks, test_errs);
          tests_run++;
          if (test_errs == 0)
            tests_ok++;
        end
        cur_id = test_id;
        test_errs = 0;
        test_checks = 0;
        if (test_id == DONE_ID) begin
          $display("summary: %0d checks, %0d errors, %0d of %0d tests passed",
                   checks, errors, tests_ok, tests_run);
          report_done = 1'b1;
        end
      end
      expect_outputs(int'(ptch), int'(ld_cell_diff), en_steer, pwr_up, integ_m, q2_m,
                     e_lspd, e_rspd, e_lrev, e_rrev, e_fast);
      compare_field("lft_spd", 16'(lft_spd), 16'(e_lspd));
      compare_field("rght_spd", 16'(rght_spd), 16'(e_rspd));
      compare_field("lft_rev", 16'(lft_rev), 16'(e_lrev));
      compare_field("rght_rev", 16'(rght_rev), 16'(e_rrev));
      compare_field("too_fast", 16'(too_fast), 16'(e_fast));
      checks++;
      test_checks++;
      err_now = clamp(int'(ptch), -512, 511);
      if (rider_off)
        integ_m = 0;   // clear wins over vld
      else if (vld && integ_m + err_now <= INTEG_MAX && integ_m + err_now >= INTEG_MIN)
        integ_m = integ_m + err_now;   // hold on overflow
      if (vld) begin
        q2_m = q1_m;
        q1_m = err_now;
      end
    end
  end

endmodule : balance_checker

//--- balance_cntrl_tb.sv
// balance controller testbench
module balance_cntrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import balance_types_pkg::*;

  // test lengths in cycles set the timeout
  localparam int N_PWR    = 40;
  localparam int N_PD     = 200;
  localparam int N_WIND   = 320;   // enough readings at +511 to hit overflow
  localparam int N_UNWIND = 640;   // unwind through zero to negative overflow
  localparam int N_CLEAR  = 30;
  localparam int N_STEER  = 150;
  localparam int N_SHAPE  = 164;   // 121 sweep points + 3 at the warn level + 40 full scale
  localparam int LIMIT    = 3 + N_PWR + N_PD + N_WIND + N_UNWIND + N_CLEAR
                            + N_STEER + N_SHAPE + 100;
  localparam logic [3:0] DONE_ID = 4'd7;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       vld, rider_off, en_steer, pwr_up;
  ptch_t      ptch;
  ld_diff_t   ld_cell_diff;
  spd_t       lft_spd, rght_spd;
  logic       lft_rev, rght_rev, too_fast;
  logic [3:0] test_id;
  int         errors, checks;
  logic       report_done;
  integer     seed = 32'h7e101174;
  int         cycles = 0;
  int         k;

  always #4 clk = ~clk;   // 8 ns period

  balance_cntrl balance_cntrl_i (
    .clk(clk), .rst_n(rst_n), .vld(vld), .ptch(ptch), .ld_cell_diff(ld_cell_diff),
    .rider_off(rider_off), .en_steer(en_steer), .pwr_up(pwr_up),
    .lft_spd(lft_spd), .rght_spd(rght_spd), .lft_rev(lft_rev), .rght_rev(rght_rev),
    .too_fast(too_fast)
  );

  balance_checker #(.DONE_ID(DONE_ID)) chk_i (
    .clk(clk), .rst_n(rst_n), .vld(vld), .ptch(ptch), .ld_cell_diff(ld_cell_diff),
    .rider_off(rider_off), .en_steer(en_steer), .pwr_up(pwr_up),
    .lft_spd(lft_spd), .rght_spd(rght_spd), .lft_rev(lft_rev), .rght_rev(rght_rev),
    .too_fast(too_fast), .test_id(test_id),
    .errors(errors), .checks(checks), .report_done(report_done)
  );

  ///////////////////////////////
  // watchdog
  ///////////////////////////////
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout: tests did not finish");
      $display("Test failed");
      $finish;
    end
  end

  // uniform integer in [lo, hi]
  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return lo + r % (hi - lo + 1);
  endfunction

  // one reading driven on the falling edge
  task automatic apply_reading(input logic v, input int p, input int ld);
    @(negedge clk);
    vld          = v;
    ptch         = ptch_t'(p);
    ld_cell_diff = ld_diff_t'(ld);
  endtask

  ///////////////////////////////
  // stimulus
  ///////////////////////////////
  initial begin
    rst_n = 1'b0;
    vld = 1'b0;
    ptch = '0;
    ld_cell_diff = '0;
    rider_off = 1'b1;
    en_steer = 1'b0;
    pwr_up = 1'b0;
    test_id = 4'd0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_id = 4'd1;     // powered down so only rev follows the sign
    rider_off = 1'b0;   // integrator winds negative while its term is gated off
    for (k = 0; k < N_PWR; k++) begin
      if (k < N_PWR / 2)
        apply_reading(rand_range(0, 1) == 1, rand_range(-1200, -600), 0);
      else
        apply_reading(1'b1, 0, 0);   // once D settles only the I term could flip rev
    end

    test_id = 4'd2;   // P and D only with the integrator held clear
    pwr_up = 1'b1;
    rider_off = 1'b1;
    for (k = 0; k < N_PD; k++)
      apply_reading(k % 5 != 4, (k % 2) ? rand_range(-40, 40) : rand_range(-1200, 1200), 0);

    test_id = 4'd3;   // wind up to the freeze and unwind with gaps in vld
    rider_off = 1'b0;
    for (k = 0; k < N_WIND; k++)
      apply_reading(k % 8 != 7, rand_range(600, 2000), 0);
    for (k = 0; k < N_UNWIND; k++)
      apply_reading(k % 8 != 7, rand_range(-2000, -600), 0);

    test_id = 4'd4;
    apply_reading(1'b0, 700, 0);
    rider_off = 1'b1;   // high for exactly one edge
    apply_reading(1'b1, 700, 0);
    rider_off = 1'b0;
    for (k = 0; k < N_CLEAR - 2; k++)
      apply_reading(1'b1, rand_range(-300, 300), 0);

    test_id = 4'd5;
    en_steer = 1'b1;
    for (k = 0; k < N_STEER; k++) begin
      if (k == 100)
        en_steer = 1'b0;   // same torque on both wheels from here
      apply_reading(1'b1, rand_range(-300, 300), rand_range(-2048, 2047));
    end

    test_id = 4'd6;   // torque = 14k + 40 walks across the band and the warn level
    rider_off = 1'b1;
    en_steer = 1'b0;
    for (k = -60; k <= 60; k++)
      apply_reading(1'b1, k, 0);
    for (k = 30; k <= 34; k += 2)
      apply_reading(1'b1, k, 0);   // last one lands both speeds on exactly 1536
    for (k = 0; k < N_SHAPE - 124; k++)
      apply_reading(1'b1, (k % 2) ? rand_range(400, 2000) : rand_range(-2000, -400), 0);

    @(negedge clk);
    test_id = DONE_ID;
    while (!report_done)
      @(negedge clk);
    if (errors == 0 && checks > 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule : balance_cntrl_tb

//--- balance_cntrl.f
balance_types_pkg.sv
balance_cfg_pkg.sv
pitch_pid.sv
wheel_shaper.sv
motor_drive.sv
balance_cntrl.sv
balance_checker.sv
balance_cntrl_tb.sv

//--- Makefile
TOP := balance_cntrl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f balance_cntrl.f --Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
